// File: hw/riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             xlen_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
  typedef logic [31:0]                 inst_t;

  localparam xlen_t RESET_PC = '0;

  // base opcodes kept in this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_e;

  // fetch/decode register
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    inst_t inst;
  } fd_payload_t;

  // decode/execute register
  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    reg_addr_t rs1_addr;
    xlen_t     rs1_data;
    reg_addr_t rs2_addr;
    xlen_t     rs2_data;
    reg_addr_t rd;
    xlen_t     imm;
    alu_op_e   alu_op;
    logic      a_is_pc;   // operand a from pc
    logic      b_is_imm;  // operand b from immediate
    logic      regw;
  } de_payload_t;

  // valid only when the result writes a nonzero rd
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
  } ex_result_t;

endpackage

// File: hw/riscv_pipe_reg.sv
module riscv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_riscv_pipe_clk,
  input  logic     i_rst,
  input  payload_t i_d,
  output payload_t o_q
);

  // all-zero clear drops the valid bit of any stage payload
  always_ff @(posedge i_riscv_pipe_clk) begin
    if (i_rst) begin
      o_q <= '0;
    end else begin
      o_q <= i_d;
    end
  end

  // nothing left in flight once reset is seen
  a_clear_after_rst : assert property (
    @(posedge i_riscv_pipe_clk) i_rst |=> (o_q == '0)
  ) else $error("stage register not cleared after reset");

endmodule

// File: hw/riscv_fstage.sv
module riscv_fstage (
  input  logic                   i_riscv_fstage_clk,
  input  logic                   i_rst,
  input  logic                   i_stall,
  input  riscv_pkg::inst_t       i_inst,
  output riscv_pkg::xlen_t       o_pc,
  output riscv_pkg::fd_payload_t o_fd
);
  import riscv_pkg::*;

  always_ff @(posedge i_riscv_fstage_clk) begin
    if (i_rst) begin
      o_pc <= RESET_PC;
      o_fd <= '0;
    end else if (!i_stall) begin
      o_pc     <= o_pc + xlen_t'(4);  // sequential fetch with no redirect
      o_fd.valid <= 1'b1;
      o_fd.pc    <= o_pc;
      o_fd.inst  <= i_inst;              // word for the current pc
    end
    // stalled edge keeps pc and fetch/decode contents
  end

  a_pc_aligned : assert property (
    @(posedge i_riscv_fstage_clk) disable iff (i_rst) o_pc[1:0] == 2'b00
  ) else $error("pc lost word alignment");

endmodule

// File: hw/riscv_regfile.sv
module riscv_regfile (
  input  logic                  i_riscv_regfile_clk,
  input  logic                  i_rst,
  input  riscv_pkg::ex_result_t i_wr,
  input  riscv_pkg::reg_addr_t  i_rs1_addr,
  input  riscv_pkg::reg_addr_t  i_rs2_addr,
  output riscv_pkg::xlen_t      o_rs1_data,
  output riscv_pkg::xlen_t      o_rs2_data
);
  import riscv_pkg::*;

  xlen_t regs [1:NUM_REGS-1];  // x0 is not stored

  always_ff @(posedge i_riscv_regfile_clk) begin
    if (i_rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.valid && (i_wr.rd != '0)) begin
      regs[i_wr.rd] <= i_wr.data;
    end
  end

  // write-first, so decode sees the value retiring this cycle
  function automatic xlen_t read_port(input reg_addr_t addr);
    xlen_t val;
    if (addr == '0) begin
      val = '0;
    end else if (i_wr.valid && (i_wr.rd == addr)) begin
      val = i_wr.data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

  a_x0_reads_zero : assert property (
    @(posedge i_riscv_regfile_clk) disable iff (i_rst)
      ((i_rs1_addr == '0) |-> (o_rs1_data == '0)) and
      ((i_rs2_addr == '0) |-> (o_rs2_data == '0))
  ) else $error("x0 read returned nonzero data");

  // execute must already have dropped writes to x0
  a_no_x0_write : assert property (
    @(posedge i_riscv_regfile_clk) disable iff (i_rst) i_wr.valid |-> (i_wr.rd != '0)
  ) else $error("retired result targets x0");

endmodule

// File: hw/riscv_dstage.sv
module riscv_dstage (
  input  logic                   i_riscv_dstage_clk,
  input  logic                   i_rst,
  input  logic                   i_stall,
  input  riscv_pkg::fd_payload_t i_fd,
  input  riscv_pkg::ex_result_t  i_wb,
  output riscv_pkg::de_payload_t o_de
);
  import riscv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      imm_i;
  xlen_t      imm_u;
  alu_op_e    alu_op;
  logic       a_is_pc;
  logic       b_is_imm;
  logic       regw;
  logic       use_imm_u;

  assign opcode   = i_fd.inst[6:0];
  assign funct3   = i_fd.inst[14:12];
  assign funct7   = i_fd.inst[31:25];
  assign rs1_addr = i_fd.inst[19:15];
  assign rs2_addr = i_fd.inst[24:20];

  assign imm_i = {{(XLEN-12){i_fd.inst[31]}}, i_fd.inst[31:20]};
  assign imm_u = {{(XLEN-32){i_fd.inst[31]}}, i_fd.inst[31:12], 12'b0};

  riscv_regfile u_riscv_regfile (
    .i_riscv_regfile_clk (i_riscv_dstage_clk),
    .i_rst               (i_rst),
    .i_wr                (i_wb),
    .i_rs1_addr          (rs1_addr),
    .i_rs2_addr          (rs2_addr),
    .o_rs1_data          (rs1_data),
    .o_rs2_data          (rs2_data)
  );

  // same funct3 map for OP and OP-IMM, alt picks sub/sra
  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin : decode
    alu_op    = ALU_ADD;
    a_is_pc   = 1'b0;
    b_is_imm  = 1'b0;
    regw      = 1'b0;  // unsupported encodings write nothing
    use_imm_u = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op = f3_to_alu(funct3, funct7[5]);
        regw   = (funct7 == 7'h00) ||
                 ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      OPC_OP_IMM: begin
        // only shifts carry funct bits; addi must never become sub
        alu_op   = f3_to_alu(funct3, (funct3 == 3'b101) && i_fd.inst[30]);
        b_is_imm = 1'b1;
        case (funct3)
          3'b001:  regw = (i_fd.inst[31:26] == 6'b000000);
          3'b101:  regw = (i_fd.inst[31:26] == 6'b000000) || (i_fd.inst[31:26] == 6'b010000);
          default: regw = 1'b1;
        endcase
      end
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        b_is_imm  = 1'b1;
        use_imm_u = 1'b1;
        regw      = 1'b1;
      end
      OPC_AUIPC: begin
        a_is_pc   = 1'b1;
        b_is_imm  = 1'b1;
        use_imm_u = 1'b1;
        regw      = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin : build_payload
    o_de.valid    = i_fd.valid && !i_stall;  // stall inserts a bubble
    o_de.pc       = i_fd.pc;
    o_de.rs1_addr = rs1_addr;
    o_de.rs1_data = rs1_data;
    o_de.rs2_addr = rs2_addr;
    o_de.rs2_data = rs2_data;
    o_de.rd       = i_fd.inst[11:7];
    o_de.imm      = use_imm_u ? imm_u : imm_i;
    o_de.alu_op   = alu_op;
    o_de.a_is_pc  = a_is_pc;
    o_de.b_is_imm = b_is_imm;
    o_de.regw     = regw;
  end

endmodule

// File: hw/riscv_estage.sv
module riscv_estage (
  input  riscv_pkg::de_payload_t i_de,
  input  riscv_pkg::ex_result_t  i_fwd_m,
  input  riscv_pkg::ex_result_t  i_fwd_w,
  output riscv_pkg::ex_result_t  o_ex
);
  import riscv_pkg::*;

  xlen_t      rs1_val;
  xlen_t      rs2_val;
  xlen_t      op_a;
  xlen_t      op_b;
  xlen_t      alu_res;
  logic [5:0] shamt;

  // youngest producer wins, x0 never matches since its valid is low
  function automatic xlen_t fwd_pick(
    input reg_addr_t  addr,
    input xlen_t      rf_data,
    input ex_result_t fwd_m,
    input ex_result_t fwd_w
  );
    xlen_t val;
    if (fwd_m.valid && (fwd_m.rd == addr)) begin
      val = fwd_m.data;
    end else if (fwd_w.valid && (fwd_w.rd == addr)) begin
      val = fwd_w.data;
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  assign rs1_val = fwd_pick(i_de.rs1_addr, i_de.rs1_data, i_fwd_m, i_fwd_w);
  assign rs2_val = fwd_pick(i_de.rs2_addr, i_de.rs2_data, i_fwd_m, i_fwd_w);

  assign op_a  = i_de.a_is_pc ? i_de.pc : rs1_val;   // auipc
  assign op_b  = i_de.b_is_imm ? i_de.imm : rs2_val;
  assign shamt = op_b[5:0];  // rv64 shift amount

  always_comb begin : alu
    case (i_de.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SLT:    alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_res = xlen_t'(op_a < op_b);
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  always_comb begin : result
    o_ex.valid = i_de.valid && i_de.regw && (i_de.rd != '0);
    o_ex.rd    = i_de.rd;
    o_ex.data  = alu_res;
  end

  // decoder must hand over a defined ALU code for live instructions
  always_comb begin : op_check
    if (i_de.valid) begin
      a_known_op : assert final (
        !$isunknown(i_de.alu_op) &&
        (i_de.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                             ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B})
      ) else $error("unknown alu_op on a valid execute payload");
    end
  end

endmodule

// File: hw/riscv_datapath.sv
module riscv_datapath (
  input  logic                  i_riscv_datapath_clk,
  input  logic                  i_rst,
  input  logic                  i_stall,
  input  riscv_pkg::inst_t      i_inst,   // word at o_pc
  output riscv_pkg::xlen_t      o_pc,
  output riscv_pkg::ex_result_t o_wb      // one pulse per retired result
);
  import riscv_pkg::*;

  fd_payload_t fd_d;     // fetch/decode register
  de_payload_t de_d;     // decode output
  de_payload_t de_e;     // decode/execute register
  ex_result_t  ex_e;     // execute output
  ex_result_t  ex_m;     // memory stage, pass-through only

  // fetch
  riscv_fstage u_riscv_fstage (
    .i_riscv_fstage_clk (i_riscv_datapath_clk),
    .i_rst              (i_rst),
    .i_stall            (i_stall),
    .i_inst             (i_inst),
    .o_pc               (o_pc),
    .o_fd               (fd_d)
  );

  // decode and register file, written from writeback
  riscv_dstage u_riscv_dstage (
    .i_riscv_dstage_clk (i_riscv_datapath_clk),
    .i_rst              (i_rst),
    .i_stall            (i_stall),
    .i_fd               (fd_d),
    .i_wb               (o_wb),
    .o_de               (de_d)
  );

  riscv_pipe_reg #(
    .payload_t (de_payload_t)
  ) u_riscv_de_ppreg (
    .i_riscv_pipe_clk (i_riscv_datapath_clk),
    .i_rst            (i_rst),
    .i_d              (de_d),
    .o_q              (de_e)
  );

  // execute, forwarding from memory then writeback
  riscv_estage u_riscv_estage (
    .i_de    (de_e),
    .i_fwd_m (ex_m),
    .i_fwd_w (o_wb),
    .o_ex    (ex_e)
  );

  riscv_pipe_reg #(
    .payload_t (ex_result_t)
  ) u_riscv_em_ppreg (
    .i_riscv_pipe_clk (i_riscv_datapath_clk),
    .i_rst            (i_rst),
    .i_d              (ex_e),
    .o_q              (ex_m)
  );

  // no data memory, result just moves on
  riscv_pipe_reg #(
    .payload_t (ex_result_t)
  ) u_riscv_mw_ppreg (
    .i_riscv_pipe_clk (i_riscv_datapath_clk),
    .i_rst            (i_rst),
    .i_d              (ex_m),
    .o_q              (o_wb)
  );

endmodule

// File: dv/tb_riscv_datapath.sv
module tb_riscv_datapath;
  timeunit 1ns;
  timeprecision 1ps;
  import riscv_pkg::*;

  localparam int    MAX_WORDS  = 64;  // program index is pc[7:2]
  localparam int    MAX_WB     = 64;
  localparam int    WB_TIMEOUT = 50;  // idle cycles allowed between writebacks
  localparam int    HIST_LEN   = 4096;
  localparam int    DRAIN      = 8;
  localparam inst_t NOP        = 32'h00000013;  // addi x0, x0, 0

  logic       clk;
  logic       rst;
  logic       stall;
  inst_t      inst;
  xlen_t      pc;
  ex_result_t wb;

  inst_t      prog [MAX_WORDS];
  ex_result_t exp_wb [MAX_WB];
  xlen_t      pc_hist [HIST_LEN];  // pc presented before each edge
  int         num_words;
  int         num_wb;
  int         seed;

  riscv_datapath riscv_datapath_inst (
    .i_riscv_datapath_clk (clk),
    .i_rst                (rst),
    .i_stall              (stall),
    .i_inst               (inst),
    .o_pc                 (pc),
    .o_wb                 (wb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_pc(input xlen_t act, input xlen_t exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] %0t ns: %s, pc 0x%016h, expected 0x%016h",
                         $time, what, act, exp));
    end
  endtask

  // an expected result with valid low means no writeback may show
  task automatic check_wb(input ex_result_t act, input ex_result_t exp, input string what);
    if (!exp.valid && (act.valid !== 1'b0)) begin
      stop_run($sformatf("[FAIL] %0t ns: %s, unexpected writeback x%0d = 0x%016h",
                         $time, what, act.rd, act.data));
    end else if (exp.valid && (act !== exp)) begin
      stop_run($sformatf("[FAIL] %0t ns: %s, got x%0d = 0x%016h, expected x%0d = 0x%016h",
                         $time, what, act.rd, act.data, exp.rd, exp.data));
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          code;
    string       line;
    logic [63:0] a;
    logic [63:0] b;
    fd = $fopen("dv/riscv_datapath_tests.txt", "r");
    if (fd == 0) begin
      stop_run("could not open dv/riscv_datapath_tests.txt");
    end
    num_words = 0;
    num_wb    = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if ((code > 0) && (line.len() > 1)) begin
        if ((line.getc(0) == "I") && (num_words < MAX_WORDS)) begin
          code = $sscanf(line.substr(1, line.len() - 1), "%h", a);
          prog[num_words] = a[31:0];
          num_words++;
        end else if ((line.getc(0) == "W") && (num_wb < MAX_WB)) begin
          code = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
          exp_wb[num_wb].valid = 1'b1;
          exp_wb[num_wb].rd    = a[4:0];
          exp_wb[num_wb].data  = b;
          num_wb++;
        end
      end
    end
    $fclose(fd);
    if ((num_words == 0) || (num_wb == 0)) begin
      stop_run("test file holds no program words or no expected writebacks");
    end
  endtask

  // instruction memory model returning nop past the program end
  function automatic inst_t fetch_word(input xlen_t addr);
    inst_t word;
    word = NOP;
    if ((addr >> 2) < xlen_t'(num_words)) begin
      word = prog[addr[7:2]];
    end
    return word;
  endfunction

  // program index of the next word whose rd field matches
  function automatic int next_writer(input int from, input reg_addr_t rd);
    int idx;
    idx = from;
    while ((idx < num_words) && (prog[idx][11:7] != rd)) begin
      idx++;
    end
    return idx;
  endfunction

  task automatic apply_reset();
    rst   = 1'b1;
    stall = 1'b0;
    inst  = NOP;
    repeat (2) begin
      @(negedge clk);
      check_pc(pc, RESET_PC, "pc during reset");
      check_wb(wb, '0, "writeback during reset");
    end
    rst = 1'b0;
  endtask

  task automatic run_program(input logic with_stall);
    int   n;
    int   wb_idx;
    int   idle;
    int   src;
    logic stalled;
    apply_reset();
    n      = 0;
    wb_idx = 0;
    idle   = 0;
    src    = -1;
    while (wb_idx < num_wb) begin
      pc_hist[n] = pc;
      inst       = fetch_word(pc);
      stalled    = with_stall && (($random(seed) & 3) == 0);
      stall      = stalled;
      @(negedge clk);
      check_pc(pc, stalled ? pc_hist[n] : pc_hist[n] + xlen_t'(4), "pc after edge");
      if (wb.valid) begin
        check_wb(wb, exp_wb[wb_idx], "retired result");
        if (!with_stall) begin
          // fetch, decode, execute, memory edges with no stall
          src = next_writer(src + 1, exp_wb[wb_idx].rd);
          check_pc(pc_hist[n - 3], xlen_t'(src * 4), "pc of word sampled 4 edges back");
        end
        wb_idx++;
        idle = 0;
      end else begin
        idle++;
        if (idle > WB_TIMEOUT) begin
          stop_run($sformatf("timeout: no writeback for %0d cycles, %0d of %0d results seen",
                             WB_TIMEOUT, wb_idx, num_wb));
        end
      end
      n++;
    end
    // nothing may retire from the nop tail
    stall = 1'b0;
    repeat (DRAIN) begin
      inst = fetch_word(pc);
      @(negedge clk);
      check_wb(wb, '0, "writeback after last result");
    end
  endtask

  initial begin
    rst     = 1'b1;
    stall   = 1'b0;
    inst    = NOP;
    seed    = 32'h4c151d00;
    load_tests();
    run_program(1'b0);
    run_program(1'b1);  // same program under random stalls
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: dv/riscv_datapath_tests.txt
# I <program word, hex>          words in pc order from address 0
# W <rd, hex> <value, hex>       expected writebacks in retirement order
I 00500093
I FFD00113
I 002081B3
I 40208233
I 0041C2B3
I 0022F333
I 001123B3
I 00113433
I 003094B3
I 40115513
I 03C15593
I 80000637
I 00001697
I 00708013
I 00006733
I 401657B3
I 7FF66813
W 01 0000000000000005
W 02 FFFFFFFFFFFFFFFD
W 03 0000000000000002
W 04 0000000000000008
W 05 000000000000000A
W 06 0000000000000008
W 07 0000000000000001
W 08 0000000000000000
W 09 0000000000000014
W 0A FFFFFFFFFFFFFFFE
W 0B 000000000000000F
W 0C FFFFFFFF80000000
W 0D 0000000000001030
W 0E 0000000000000000
W 0F FFFFFFFFFC000000
W 10 FFFFFFFF800007FF

// File: tb.f
hw/riscv_pkg.sv
hw/riscv_pipe_reg.sv
hw/riscv_fstage.sv
hw/riscv_regfile.sv
hw/riscv_dstage.sv
hw/riscv_estage.sv
hw/riscv_datapath.sv
dv/tb_riscv_datapath.sv

// File: Makefile
TOP := tb_riscv_datapath
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ)
